//--- slurm16_golden.txt
# kind address value: P = program word at a ROM address, R = data an IN from a port returns,
# W = expected OUT to a port, in the order the writes must appear.
P 0000 8f10
P 0001 8134
P 0002 9112
P 0003 82f0
P 0004 1312
P 0005 2421
P 0006 3543
P 0007 4652
P 0008 5764
P 0009 6977
P 000a 7a77
P 000b 5b9a
P 000c c0fb
P 000d c0f3
P 000e c0f4
P 000f c0f7
P 0010 a501
P 0011 c0f5
P 0012 2c11
P 0013 ac01
P 0014 c0f1
P 0015 b001
P 0016 c0f2
P 0017 ddf0
P 0018 c0fd
P 0019 f000
R 0010 a5c3
W 0010 48ec
W 0010 1324
W 0010 eebc
W 0010 ec48
W 0010 0224
W 0010 a5c3

//--- compile.f
+incdir+.
slurm16_pkg.sv
slurm16_cpu_decode.sv
slurm16_cpu_execute.sv
slurm16_cpu_top.sv
slurm16_cpu_checker.sv
slurm16_cpu_tb.sv

//--- slurm16_cpu_tb.sv
/*
 * Testbench for the SLURM16 core. Reads program words, port read data and the expected
 * port writes from the golden file, then runs the program against a ROM model and an
 * APB slave model with random wait states until the core halts.
 */

`timescale 1ns/1ps
`default_nettype none

module slurm16_cpu_tb
	import slurm16_pkg::*;
();

	logic     CLK = 1'b0;
	logic     reset;
	addr_t    instr_address;
	instr_t   instr_data;
	apb_req_t apb_req;
	word_t    apb_prdata;
	logic     apb_pready;
	logic     halted;

	instr_t rom [0:65535];

	// IN responses by port address, and the expected OUT sequence in order.
	addr_t r_addr_q[$];
	word_t r_data_q[$];
	addr_t w_addr_q[$];
	word_t w_data_q[$];
	int    w_idx = 0;
	int    prog_len = 0;

	int wait_left = 0;
	int value_errors = 0;
	int other_errors = 0;
	int cycle_count = 0;
	int timeout_cycles = 0;
	int unsigned seed_sink;

	always #2 CLK = ~CLK;

	assign instr_data = rom[instr_address]; // the fetch port answers in the same cycle.

	slurm16_cpu_top i_dut (
		.CLK           (CLK),
		.reset         (reset),
		.instr_address (instr_address),
		.instr_data    (instr_data),
		.apb_req       (apb_req),
		.apb_prdata    (apb_prdata),
		.apb_pready    (apb_pready),
		.halted        (halted)
	);

	bind slurm16_cpu_execute slurm16_cpu_checker i_checker (
		.CLK     (CLK),
		.reset   (reset),
		.apb_req (apb_req),
		.halted  (halted)
	);

	task automatic load_golden();
		int fd;
		int n;
		int ch;
		logic [7:0] kind;
		addr_t addr;
		word_t data;
		addr_t fill_addr;
		// unloaded words are OUT instructions whose register fields follow the whole address.
		for (int i = 0; i < 65536; i++) begin
			fill_addr = i[15:0];
			rom[fill_addr] = {4'hc, fill_addr[11:0] ^ {8'h00, fill_addr[15:12]}};
		end
		fd = $fopen("slurm16_golden.txt", "r");
		assert (fd != 0) else begin
			other_errors++;
			$display("cannot open the golden file slurm16_golden.txt");
		end
		while (fd != 0 && !$feof(fd)) begin
			n = $fscanf(fd, " %c", kind);
			if (n == 1 && kind == "#") begin
				ch = $fgetc(fd);
				while (ch != "\n" && ch != -1) begin
					ch = $fgetc(fd);
				end
			end else if (n == 1) begin
				n = $fscanf(fd, "%h %h", addr, data);
				case (kind)
					"P": begin
						rom[addr] = data;
						prog_len++;
					end
					"R": begin
						r_addr_q.push_back(addr);
						r_data_q.push_back(data);
					end
					"W": begin
						w_addr_q.push_back(addr);
						w_data_q.push_back(data);
					end
					default: begin
						other_errors++;
						$display("unknown record kind %c in the golden file", kind);
					end
				endcase
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
	endtask

	function automatic int find_port(addr_t addr);
		for (int i = 0; i < r_addr_q.size(); i++) begin
			if (r_addr_q[i] == addr) begin
				return i;
			end
		end
		return -1;
	endfunction

	// called on the falling edge where pready goes high, so the transfer ends next clock.
	task automatic finish_transfer();
		int idx;
		if (apb_req.pwrite) begin
			assert (w_idx < w_addr_q.size()) else begin
				other_errors++;
				$display("unexpected port write of 0x%h to 0x%h", apb_req.pwdata, apb_req.paddr);
			end
			if (w_idx < w_addr_q.size()) begin
				assert (apb_req.paddr == w_addr_q[w_idx]) else begin
					value_errors++;
					$display("Fail paddr exp 0x%h got 0x%h", w_addr_q[w_idx], apb_req.paddr);
				end
				assert (apb_req.pwdata == w_data_q[w_idx]) else begin
					value_errors++;
					$display("Fail pwdata exp 0x%h got 0x%h", w_data_q[w_idx], apb_req.pwdata);
				end
				w_idx++;
			end
		end else begin
			idx = find_port(apb_req.paddr);
			assert (idx >= 0) else begin
				other_errors++;
				$display("port read from 0x%h has no response in the golden file", apb_req.paddr);
			end
			apb_prdata = (idx >= 0) ? r_data_q[idx] : '0;
		end
	endtask

	function automatic int total_errors();
		return value_errors + other_errors + i_dut.i_execute.i_checker.assert_failures;
	endfunction

	task automatic report_counts();
		$display("errors: %0d value, %0d other, %0d assertion", value_errors, other_errors,
			i_dut.i_execute.i_checker.assert_failures);
	endtask

	// APB slave model. The setup cycle picks 0 to 2 wait states for the access phase.
	always @(negedge CLK) begin
		apb_pready = 1'b0;
		if (reset === 1'b0 && apb_req.psel === 1'b1) begin
			if (apb_req.penable !== 1'b1) begin
				assert (halted !== 1'b1) else begin
					other_errors++;
					$display("port transfer to 0x%h started after the core halted", apb_req.paddr);
				end
				wait_left = $urandom % 3;
			end else if (wait_left != 0) begin
				wait_left--;
			end else begin
				apb_pready = 1'b1;
				finish_transfer();
			end
		end
	end

	initial begin
		seed_sink = $urandom(32'hfe97_2ca5);
		reset = 1'b1;
		apb_prdata = '0;
		apb_pready = 1'b0;
		load_golden();
		timeout_cycles = (prog_len + w_addr_q.size() * 4 + 50) * 4;
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;
		while (halted !== 1'b1) begin
			@(negedge CLK);
		end
		repeat (10) @(negedge CLK); // traffic behind the HALT would show up here.
		assert (w_idx == w_addr_q.size()) else begin
			other_errors++;
			$display("only %0d of %0d expected port writes seen before halt", w_idx,
				w_addr_q.size());
		end
		report_counts();
		if (total_errors() == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		wait (timeout_cycles != 0);
		while (cycle_count < timeout_cycles) begin
			@(posedge CLK);
			cycle_count++;
		end
		other_errors++;
		$display("timeout after %0d cycles, halted not seen, %0d of %0d port writes seen",
			cycle_count, w_idx, w_addr_q.size());
		report_counts();
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- slurm16_cpu_checker.sv
/*
 * Concurrent assertions on the APB port and the halt output of the execute stage.
 * The testbench binds this module into the execute stage and reads the failure count.
 */

`timescale 1ns/1ps
`default_nettype none

module slurm16_cpu_checker
	import slurm16_pkg::*;
(
	input  wire logic     CLK,
	input  wire logic     reset,
	input  wire apb_req_t apb_req,
	input  wire logic     halted
);

	int assert_failures = 0; // failed assertions so far.

	// every transfer opens with exactly one setup cycle before penable.
	penable_after_setup: assert property (@(posedge CLK) disable iff (reset)
		$rose(apb_req.penable) |-> apb_req.psel && $past(apb_req.psel))
	else begin
		$error("penable rose without a setup cycle before it");
		assert_failures++;
	end

	// An access cycle always follows a cycle of the same transfer,
	// so the request fields may not move while penable is high.
	request_stable: assert property (@(posedge CLK) disable iff (reset)
		apb_req.penable |-> $stable(apb_req.paddr) && $stable(apb_req.pwrite) &&
			$stable(apb_req.pwdata))
	else begin
		$error("paddr, pwrite or pwdata changed during a transfer");
		assert_failures++;
	end

	psel_low_after_reset: assert property (@(posedge CLK) reset |=> !apb_req.psel)
	else begin
		$error("psel was high in the cycle after reset");
		assert_failures++;
	end

	halted_sticky: assert property (@(posedge CLK) disable iff (reset) halted |=> halted)
	else begin
		$error("halted fell without a reset");
		assert_failures++;
	end

endmodule

`default_nettype wire

//--- slurm16_cpu_top.sv
/*
 * Top level of the reduced SLURM16 core. Connects the decode and execute stages to
 * the combinational instruction port and to the APB port bus.
 */

`timescale 1ns/1ps
`default_nettype none

module slurm16_cpu_top
	import slurm16_pkg::*;
(
	input  wire logic   CLK,
	input  wire logic   reset,

	output addr_t       instr_address,
	input  wire instr_t instr_data,

	output apb_req_t    apb_req,
	input  wire word_t  apb_prdata,
	input  wire logic   apb_pready,

	output logic        halted
);

	dec_ex_t   dec_ex;
	reg_wr_t   reg_wr;   // also the register file write port.
	redirect_t redirect;
	logic      stall;    // high while a port transfer is still running.

	slurm16_cpu_decode i_decode (
		.CLK           (CLK),
		.reset         (reset),
		.instr_address (instr_address),
		.instr_data    (instr_data),
		.reg_wr        (reg_wr),
		.redirect      (redirect),
		.stall         (stall),
		.halted        (halted),
		.dec_ex        (dec_ex)
	);

	slurm16_cpu_execute i_execute (
		.CLK        (CLK),
		.reset      (reset),
		.dec_ex     (dec_ex),
		.reg_wr     (reg_wr),
		.redirect   (redirect),
		.stall      (stall),
		.halted     (halted),
		.apb_req    (apb_req),
		.apb_prdata (apb_prdata),
		.apb_pready (apb_pready)
	);

endmodule

`default_nettype wire

//--- slurm16_cpu_execute.sv
/*
 * Execute stage of the SLURM16 core with the ALU, branch resolution, the APB master
 * for OUT and IN, and the writeback register that feeds both the register file and
 * the operand forwarding path.
 */

`timescale 1ns/1ps
`default_nettype none

`include "slurm16_cfg.svh"

module slurm16_cpu_execute
	import slurm16_pkg::*;
(
	input  wire logic    CLK,
	input  wire logic    reset,

	input  wire dec_ex_t dec_ex,

	output reg_wr_t      reg_wr,
	output redirect_t    redirect,
	output logic         stall,
	output logic         halted,

	output apb_req_t     apb_req,
	input  wire word_t   apb_prdata,
	input  wire logic    apb_pready
);

	apb_state_e state;
	apb_state_e phase; // state as seen in this cycle, including the setup cycle.

	word_t op_a;
	word_t op_b;
	logic  exec_valid;
	logic  io_op;
	logic  transfer_done;

	word_t alu_result;
	logic  alu_write;
	addr_t branch_target;

	// transfer payload, captured in the setup cycle and held through the access cycles.
	addr_t apb_addr_q;
	word_t apb_wdata_q;
	logic  apb_write_q;

	// the previous instruction's result is not yet in the register file.
	assign op_a = (reg_wr.valid && reg_wr.rd == dec_ex.ra_sel) ? reg_wr.data : dec_ex.a_val;
	assign op_b = (reg_wr.valid && reg_wr.rd == dec_ex.rb_sel) ? reg_wr.data : dec_ex.b_val;

	assign exec_valid = dec_ex.valid && (state != ST_HALTED);
	assign io_op = exec_valid && (dec_ex.op == OP_OUT || dec_ex.op == OP_IN);

	// relative to the instruction after the branch.
	assign branch_target = dec_ex.pc + addr_t'(1) +
		{{(`SLURM16_ADDR_BITS - 8){dec_ex.imm[7]}}, dec_ex.imm};

	always_comb begin
		alu_result = op_a;
		alu_write = exec_valid;
		case (dec_ex.op)
			OP_ADD: alu_result = op_a + op_b;
			OP_SUB: alu_result = op_a - op_b;
			OP_AND: alu_result = op_a & op_b;
			OP_OR:  alu_result = op_a | op_b;
			OP_XOR: alu_result = op_a ^ op_b;
			OP_SHL: alu_result = op_a << op_b[3:0];
			OP_SHR: alu_result = op_a >> op_b[3:0]; // logical, zeros shifted in.
			OP_LDL: alu_result = {8'h00, dec_ex.imm};
			OP_LDH: alu_result = {dec_ex.imm, op_a[7:0]};
			default: alu_write = 1'b0; // no register result.
		endcase
	end

	always_comb begin
		redirect.target = branch_target;
		redirect.taken = exec_valid &&
			((dec_ex.op == OP_BZ && op_a == '0) || dec_ex.op == OP_JMP);
	end

	// The first cycle of OUT or IN is the setup phase, so a transfer with no wait
	// state spends two cycles in execute.
	always_comb begin
		phase = state;
		if (state == ST_IDLE && io_op) begin
			phase = ST_SETUP;
		end
	end

	assign transfer_done = (phase == ST_ACCESS) && apb_pready;

	assign stall = (phase == ST_SETUP) || (phase == ST_ACCESS && !apb_pready);
	assign halted = (state == ST_HALTED);

	always_comb begin
		apb_req.psel = (phase == ST_SETUP) || (phase == ST_ACCESS);
		apb_req.penable = (phase == ST_ACCESS);
		if (phase == ST_SETUP) begin
			apb_req.pwrite = (dec_ex.op == OP_OUT);
			apb_req.paddr = op_a;  // port address from ra.
			apb_req.pwdata = op_b; // OUT data from rb.
		end else begin
			apb_req.pwrite = apb_write_q;
			apb_req.paddr = apb_addr_q;
			apb_req.pwdata = apb_wdata_q;
		end
	end

	always_ff @(posedge CLK) begin
		if (phase == ST_SETUP) begin
			apb_write_q <= (dec_ex.op == OP_OUT);
			apb_addr_q <= op_a;
			apb_wdata_q <= op_b;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			case (phase)
				ST_SETUP: state <= ST_ACCESS;
				ST_ACCESS: begin
					if (apb_pready) begin
						state <= ST_IDLE;
					end
				end
				ST_IDLE: begin
					if (exec_valid && dec_ex.op == OP_HALT) begin
						state <= ST_HALTED; // only reset leaves this.
					end
				end
				default: state <= state;
			endcase
		end
	end

	// Writeback register. ALU results are taken in their single execute cycle, and
	// IN data on the clock that completes the transfer.
	always_ff @(posedge CLK) begin
		if (reset) begin
			reg_wr.valid <= 1'b0;
		end else begin
			reg_wr.valid <= (phase == ST_IDLE && alu_write) || (transfer_done && !apb_write_q);
		end
		reg_wr.rd <= dec_ex.rd;
		reg_wr.data <= transfer_done ? apb_prdata : alu_result;
	end

endmodule

`default_nettype wire

//--- slurm16_cpu_decode.sv
/*
 * Fetch and decode stage of the SLURM16 core. Holds the program counter, reads the
 * program over a combinational port, splits the word into fields and reads the register file.
 * The decoded word is registered into dec_ex for the execute stage.
 */

`timescale 1ns/1ps
`default_nettype none

`include "slurm16_cfg.svh"

module slurm16_cpu_decode
	import slurm16_pkg::*;
(
	input  wire logic      CLK,
	input  wire logic      reset,

	output addr_t          instr_address,
	input  wire instr_t    instr_data,

	input  wire reg_wr_t   reg_wr,    // write port, driven by the writeback register.
	input  wire redirect_t redirect,
	input  wire logic      stall,
	input  wire logic      halted,

	output dec_ex_t        dec_ex
);

	addr_t pc;

	opcode_e  op;
	reg_sel_t rd_field;
	reg_sel_t ra_field;
	reg_sel_t rb_field;
	imm8_t    imm_field;

	reg_sel_t ra_sel;
	reg_sel_t rb_sel;
	word_t    a_val;
	word_t    b_val;

	dec_ex_t dec_next;

	// the sixteen general purpose registers of the core.
	word_t regs [0:(1 << `SLURM16_REG_SEL_BITS) - 1];

	assign instr_address = pc; // the testbench ROM answers in the same cycle.

	assign op        = opcode_e'(instr_data[15:12]);
	assign rd_field  = instr_data[11:8];
	assign ra_field  = instr_data[7:4];
	assign rb_field  = instr_data[3:0];
	assign imm_field = instr_data[7:0];

	// LDH keeps the low byte of rd and BZ tests rd, so rd is read on the a side for both.
	assign ra_sel = (op == OP_LDH || op == OP_BZ) ? rd_field : ra_field;
	assign rb_sel = rb_field;

	// a write landing in this same cycle is passed straight through to the readers.
	assign a_val = (reg_wr.valid && reg_wr.rd == ra_sel) ? reg_wr.data : regs[ra_sel];
	assign b_val = (reg_wr.valid && reg_wr.rd == rb_sel) ? reg_wr.data : regs[rb_sel];

	always_ff @(posedge CLK) begin
		if (reg_wr.valid) begin
			regs[reg_wr.rd] <= reg_wr.data;
		end
	end

	always_comb begin
		dec_next.valid  = 1'b1;
		dec_next.op     = op;
		dec_next.rd     = rd_field;
		dec_next.ra_sel = ra_sel;
		dec_next.rb_sel = rb_sel;
		dec_next.a_val  = a_val;
		dec_next.b_val  = b_val;
		dec_next.imm    = imm_field;
		dec_next.pc     = pc;
	end

	// Once halted, nothing more is fetched. A taken branch throws away the word
	// fetched behind it and restarts at the target; a stall freezes pc and dec_ex.
	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= `SLURM16_RESET_PC;
			dec_ex.valid <= 1'b0;
		end else if (halted) begin
			dec_ex.valid <= 1'b0;
		end else if (redirect.taken) begin
			pc <= redirect.target;
			dec_ex.valid <= 1'b0; // the one bubble of a taken branch.
		end else if (!stall) begin
			pc <= pc + addr_t'(1);
			dec_ex <= dec_next;
		end
	end

endmodule

`default_nettype wire

//--- slurm16_pkg.sv
/*
 * Shared types of the SLURM16 core: the word typedefs, the opcode encoding,
 * the stage words passed between decode and execute, and the APB request bundle.
 */

`include "slurm16_cfg.svh"

`default_nettype none

package slurm16_pkg;

	typedef logic [`SLURM16_WORD_BITS - 1:0] word_t;
	typedef logic [`SLURM16_ADDR_BITS - 1:0] addr_t;
	typedef logic [`SLURM16_WORD_BITS - 1:0] instr_t;
	typedef logic [`SLURM16_REG_SEL_BITS - 1:0] reg_sel_t;
	typedef logic [7:0] imm8_t; // immediate in bits 7:0 of the instruction.

	// opcode in bits 15:12 of the instruction word.
	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_OR   = 4'h4,
		OP_XOR  = 4'h5,
		OP_SHL  = 4'h6,
		OP_SHR  = 4'h7,
		OP_LDL  = 4'h8,
		OP_LDH  = 4'h9,
		OP_BZ   = 4'ha,
		OP_JMP  = 4'hb,
		OP_OUT  = 4'hc,
		OP_IN   = 4'hd,
		OP_RSVD = 4'he, // behaves as a nop.
		OP_HALT = 4'hf
	} opcode_e;

	// decoded instruction with its register operands, as presented to execute.
	typedef struct packed {
		logic     valid;
		opcode_e  op;
		reg_sel_t rd;
		reg_sel_t ra_sel; // the rd field for LDH and BZ.
		reg_sel_t rb_sel;
		word_t    a_val;
		word_t    b_val;
		imm8_t    imm;
		addr_t    pc;
	} dec_ex_t;

	typedef struct packed {
		logic     valid;
		reg_sel_t rd;
		word_t    data;
	} reg_wr_t;

	typedef struct packed {
		logic  taken;
		addr_t target;
	} redirect_t;

	typedef struct packed {
		logic  psel;
		logic  penable;
		logic  pwrite;
		addr_t paddr;
		word_t pwdata;
	} apb_req_t;

	// the setup phase exists only for the first cycle of a port instruction in execute.
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SETUP,
		ST_ACCESS,
		ST_HALTED
	} apb_state_e;

endpackage

`default_nettype wire

//--- slurm16_cfg.svh
/*
 * Width and reset-vector macros for the reduced SLURM16 core.
 * Included by the package and by any RTL file that needs a raw width or the reset pc.
 */

`ifndef SLURM16_CFG_SVH
`define SLURM16_CFG_SVH

// data path width, one machine word.
`define SLURM16_WORD_BITS 16

// instruction fetch addresses and port addresses share this width.
`define SLURM16_ADDR_BITS 16

`define SLURM16_REG_SEL_BITS 4 // sixteen general purpose registers.

// first instruction fetched once reset is released.
`define SLURM16_RESET_PC 16'h0000

`endif
